/* design/exec_defines.svh */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath word width
`define EXEC_XLEN 32

// Physical register tag width
`define EXEC_PHYS_W 6

// Reorder buffer index width
`define EXEC_ROB_W 6

`endif

/* design/isa_pkg.sv */
package isa_pkg;

    // Major opcode field
    typedef enum logic [5:0] {
        R_TYPE = 6'b000000,
        ADDI   = 6'b001000,
        SUBI   = 6'b001001,
        ANDI   = 6'b001010,
        ORI    = 6'b001011,
        EORI   = 6'b001100
    } opcode_e;

    // R-type function field
    typedef enum logic [5:0] {
        ADD  = 6'b100000,
        SUB  = 6'b100010,
        AND  = 6'b100100,
        ORR  = 6'b100101,
        EOR  = 6'b100110,
        NEG  = 6'b101000,
        CMP  = 6'b101010,
        LSL  = 6'b000000,
        LSLI = 6'b000001,
        LSR  = 6'b000010,
        LSRI = 6'b000011,
        RET  = 6'b111000
    } func_e;

    // Op word as issued, opcode in the upper half
    typedef struct packed {
        opcode_e opcode;
        func_e   func;
    } alu_op_t;

    // Ops that write NZCV
    function automatic logic sets_flags(alu_op_t op);
        if (op.opcode == R_TYPE)
            return op.func inside {ADD, SUB, CMP};
        return op.opcode inside {ADDI, SUBI};
    endfunction

endpackage

/* design/core_pkg.sv */
`include "exec_defines.svh"

package core_pkg;

    // Word width for sign and carry bit positions
    localparam int XLEN = `EXEC_XLEN;

    // ====================
    // Datapath types
    // ====================

    // Operand and result word
    typedef logic [`EXEC_XLEN-1:0] word_t;

    // Physical register tag
    typedef logic [`EXEC_PHYS_W-1:0] preg_tag_t;

    // ROB entry index
    typedef logic [`EXEC_ROB_W-1:0] rob_tag_t;

    // Condition flags, n in the top bit
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

endpackage

/* design/exec_issue_if.sv */
`timescale 1ns/1ps

interface exec_issue_if import isa_pkg::*, core_pkg::*; ();

    // One-cycle strobe per accepted instruction
    logic      valid;
    alu_op_t   op;
    preg_tag_t dst_tag;
    rob_tag_t  rob_tag;
    // Operands already resolved
    word_t     src1;
    word_t     src2;

    // Bypass stage drives the bundle
    modport source (
        output valid, op, dst_tag, rob_tag, src1, src2
    );

    // ALU consumes the bundle
    modport sink (
        input valid, op, dst_tag, rob_tag, src1, src2
    );

endinterface

/* design/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass import isa_pkg::*, core_pkg::*; (
    input  logic       issue_valid,
    input  alu_op_t    issue_op,
    input  preg_tag_t  issue_dst_tag,
    input  rob_tag_t   issue_rob_tag,
    input  preg_tag_t  issue_src1_tag,
    input  logic       issue_src1_ready,
    input  word_t      issue_src1_val,
    input  preg_tag_t  issue_src2_tag,
    input  logic       issue_src2_ready,
    input  word_t      issue_src2_val,
    input  logic       cdb_valid,
    input  preg_tag_t  cdb_tag,
    input  word_t      cdb_value,
    input  logic       byp_valid,
    input  preg_tag_t  byp_tag,
    input  word_t      byp_value,
    output logic       issue_accept,
    exec_issue_if.source issue
);

    word_t src1_val;
    word_t src2_val;
    logic  src1_ok;
    logic  src2_ok;

    // Ready value first, then ALU bypass, then CDB
    function automatic void resolve(
        input  logic      ready,
        input  preg_tag_t tag,
        input  word_t     own_val,
        output word_t     val,
        output logic      ok
    );
        val = own_val;
        ok  = 1'b1;
        if (!ready) begin
            if (byp_valid && (byp_tag == tag))
                val = byp_value;
            else if (cdb_valid && (cdb_tag == tag))
                val = cdb_value;
            else
                ok = 1'b0;  // still waiting on a producer
        end
    endfunction

    always_comb begin
        resolve(issue_src1_ready, issue_src1_tag, issue_src1_val, src1_val, src1_ok);
        resolve(issue_src2_ready, issue_src2_tag, issue_src2_val, src2_val, src2_ok);
    end

    // Unresolved issue is dropped and re-presented by the station
    assign issue_accept = issue_valid && src1_ok && src2_ok;

    // ====================
    // Resolved bundle
    // ====================
    assign issue.valid   = issue_accept;
    assign issue.op      = issue_op;
    assign issue.dst_tag = issue_dst_tag;
    assign issue.rob_tag = issue_rob_tag;
    assign issue.src1    = src1_val;
    assign issue.src2    = src2_val;

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu import isa_pkg::*, core_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    exec_issue_if.sink issue,
    output logic       result_valid,
    output preg_tag_t  result_tag,
    output word_t      result_value,
    output rob_tag_t   result_rob_tag,
    output logic       bypass_valid,
    output preg_tag_t  bypass_tag,
    output word_t      bypass_value,
    output nzcv_t      res_flags,
    output logic       res_sets_flags
);

    word_t          a;
    word_t          b;
    word_t          alu_result;
    logic           known;
    logic           is_add;
    logic           is_sub;
    logic [XLEN:0]  sum;
    logic [XLEN:0]  diff;
    nzcv_t          flags_next;

    assign a = issue.src1;
    assign b = issue.src2;

    // Widened so the top bit holds carry or borrow
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    // ====================
    // Op decode
    // ====================
    always_comb begin
        alu_result = '0;
        known      = 1'b1;
        is_add     = 1'b0;
        is_sub     = 1'b0;
        case (issue.op.opcode)
            R_TYPE: begin
                case (issue.op.func)
                    ADD:  begin alu_result = sum[XLEN-1:0];  is_add = 1'b1; end
                    SUB:  begin alu_result = diff[XLEN-1:0]; is_sub = 1'b1; end
                    AND:  alu_result = a & b;
                    ORR:  alu_result = a | b;
                    EOR:  alu_result = a ^ b;
                    NEG:  alu_result = '0 - a;
                    // Compare writes a result too, flags are the point
                    CMP:  begin alu_result = diff[XLEN-1:0]; is_sub = 1'b1; end
                    LSL, LSLI: alu_result = a << b[4:0];
                    LSR, LSRI: alu_result = a >> b[4:0];
                    // Return address passes through
                    RET:  alu_result = a;
                    default: known = 1'b0;
                endcase
            end
            // Immediate forms, imm arrives in src2
            ADDI: begin alu_result = sum[XLEN-1:0];  is_add = 1'b1; end
            SUBI: begin alu_result = diff[XLEN-1:0]; is_sub = 1'b1; end
            ANDI: alu_result = a & b;
            ORI:  alu_result = a | b;
            EORI: alu_result = a ^ b;
            default: known = 1'b0;
        endcase
    end

    // ====================
    // NZCV
    // ====================
    always_comb begin
        flags_next.n = alu_result[XLEN-1];
        flags_next.z = (alu_result == '0);
        // Carry out for add, no-borrow for subtract
        flags_next.c = (is_add && sum[XLEN]) || (is_sub && !diff[XLEN]);
        flags_next.v = (is_add && (a[XLEN-1] == b[XLEN-1]) && (alu_result[XLEN-1] != a[XLEN-1]))
                    || (is_sub && (a[XLEN-1] != b[XLEN-1]) && (alu_result[XLEN-1] != a[XLEN-1]));
    end

    // Valid only for a recognized op
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue.valid && known;
        end
    end

    // Payload stage
    always_ff @(posedge clk) begin
        result_tag     <= issue.dst_tag;
        result_value   <= alu_result;
        result_rob_tag <= issue.rob_tag;
        res_flags      <= flags_next;
        res_sets_flags <= sets_flags(issue.op);
    end

    // Bypass mirrors the broadcast in the same cycle
    assign bypass_valid = result_valid;
    assign bypass_tag   = result_tag;
    assign bypass_value = result_value;

endmodule

/* design/flag_register.sv */
`timescale 1ns/1ps

module flag_register import core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  res_valid,
    input  logic  res_sets_flags,
    input  nzcv_t res_flags,
    output nzcv_t flags
);

    logic load;

    // Only flag-setting results touch NZCV
    assign load = res_valid && res_sets_flags;

    // ====================
    // Architectural NZCV
    // ====================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (load) begin
            flags <= res_flags;
        end
    end

endmodule

/* design/alu_exec_unit.sv */
`timescale 1ns/1ps

module alu_exec_unit import isa_pkg::*, core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // Issue from the reservation station
    input  logic      issue_valid,
    input  alu_op_t   issue_op,
    input  preg_tag_t issue_dst_tag,
    input  rob_tag_t  issue_rob_tag,
    input  preg_tag_t issue_src1_tag,
    input  logic      issue_src1_ready,
    input  word_t     issue_src1_val,
    input  preg_tag_t issue_src2_tag,
    input  logic      issue_src2_ready,
    input  word_t     issue_src2_val,
    // Broadcasts from other units
    input  logic      cdb_valid,
    input  preg_tag_t cdb_tag,
    input  word_t     cdb_value,
    output logic      issue_accept,
    // CDB broadcast out
    output logic      result_valid,
    output preg_tag_t result_tag,
    output word_t     result_value,
    output rob_tag_t  result_rob_tag,
    output logic      bypass_valid,
    output preg_tag_t bypass_tag,
    output word_t     bypass_value,
    output nzcv_t     flags
);

    nzcv_t res_flags;
    logic  res_sets_flags;

    exec_issue_if issue_bus ();

    // ====================
    // Operand resolve
    // ====================
    operand_bypass u_bypass (
        .issue_valid      (issue_valid),
        .issue_op         (issue_op),
        .issue_dst_tag    (issue_dst_tag),
        .issue_rob_tag    (issue_rob_tag),
        .issue_src1_tag   (issue_src1_tag),
        .issue_src1_ready (issue_src1_ready),
        .issue_src1_val   (issue_src1_val),
        .issue_src2_tag   (issue_src2_tag),
        .issue_src2_ready (issue_src2_ready),
        .issue_src2_val   (issue_src2_val),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        // Own result loops back for dependent issues
        .byp_valid        (bypass_valid),
        .byp_tag          (bypass_tag),
        .byp_value        (bypass_value),
        .issue_accept     (issue_accept),
        .issue            (issue_bus.source)
    );

    // Execute stage
    alu u_alu (
        .clk            (clk),
        .reset          (reset),
        .issue          (issue_bus.sink),
        .result_valid   (result_valid),
        .result_tag     (result_tag),
        .result_value   (result_value),
        .result_rob_tag (result_rob_tag),
        .bypass_valid   (bypass_valid),
        .bypass_tag     (bypass_tag),
        .bypass_value   (bypass_value),
        .res_flags      (res_flags),
        .res_sets_flags (res_sets_flags)
    );

    // NZCV commit, one cycle behind the result
    flag_register u_flags (
        .clk            (clk),
        .reset          (reset),
        .res_valid      (result_valid),
        .res_sets_flags (res_sets_flags),
        .res_flags      (res_flags),
        .flags          (flags)
    );

endmodule

/* sim/alu_exec_checker.sv */
`timescale 1ns/1ps

module alu_exec_checker import core_pkg::*; (
    input logic      clk,
    input logic      reset,
    input logic      issue_valid,
    input logic      issue_accept,
    input logic      result_valid,
    input preg_tag_t result_tag,
    input word_t     result_value,
    input logic      bypass_valid,
    input preg_tag_t bypass_tag,
    input word_t     bypass_value
);

    // Count of failed properties
    int unsigned fail_count = 0;

    // No broadcast while reset holds
    quiet_in_reset: assert property (@(negedge clk) reset |-> !result_valid)
        else begin
            fail_count++;
            $error("result_valid high while reset is asserted");
        end

    // Bypass is the broadcast seen from inside
    bypass_mirrors_result: assert property (@(posedge clk) disable iff (reset)
        (bypass_valid == result_valid)
        && (!result_valid || (bypass_tag == result_tag && bypass_value == result_value)))
        else begin
            fail_count++;
            $error("bypass outputs differ from result outputs");
        end

    // Dropped issue never turns into a result
    drop_gives_no_result: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_accept) |=> !result_valid)
        else begin
            fail_count++;
            $error("result_valid after an issue that was not accepted");
        end

endmodule

/* sim/alu_exec_tb.sv */
`timescale 1ns/1ps
`include "exec_defines.svh"

module alu_exec_tb import isa_pkg::*, core_pkg::*; ();

    localparam int PERIOD     = 20;
    localparam int RESET_CYC  = 10;
    localparam int N_RANDOM   = 400;
    // Upper bound on directed issue and idle cycles
    localparam int N_DIRECTED = 80;
    localparam longint SMAX   = (64'sd1 <<< (`EXEC_XLEN - 1)) - 1;
    localparam longint SMIN   = -SMAX - 1;

    // Expected broadcast for one issue cycle
    typedef struct {
        logic      valid;
        word_t     value;
        preg_tag_t tag;
        rob_tag_t  rob;
        nzcv_t     flags;
        logic      sets;
    } exp_t;

    logic      clk;
    logic      reset;
    logic      issue_valid;
    alu_op_t   issue_op;
    preg_tag_t issue_dst_tag;
    rob_tag_t  issue_rob_tag;
    preg_tag_t issue_src1_tag;
    logic      issue_src1_ready;
    word_t     issue_src1_val;
    preg_tag_t issue_src2_tag;
    logic      issue_src2_ready;
    word_t     issue_src2_val;
    logic      cdb_valid;
    preg_tag_t cdb_tag;
    word_t     cdb_value;
    logic      issue_accept;
    logic      result_valid;
    preg_tag_t result_tag;
    word_t     result_value;
    rob_tag_t  result_rob_tag;
    logic      bypass_valid;
    preg_tag_t bypass_tag;
    word_t     bypass_value;
    nzcv_t     flags;

    int    seed = 5;
    int    results_seen = 0;
    exp_t  sb[$];
    nzcv_t model_flags = '0;

    // All recognized ops (func ignored for I-type)
    alu_op_t known_ops[17] = '{
        '{R_TYPE, ADD}, '{R_TYPE, SUB}, '{R_TYPE, AND}, '{R_TYPE, ORR},
        '{R_TYPE, EOR}, '{R_TYPE, NEG}, '{R_TYPE, CMP}, '{R_TYPE, LSL},
        '{R_TYPE, LSLI}, '{R_TYPE, LSR}, '{R_TYPE, LSRI}, '{R_TYPE, RET},
        '{ADDI, ADD}, '{SUBI, ADD}, '{ANDI, ADD}, '{ORI, ADD}, '{EORI, ADD}
    };

    alu_exec_unit DUT (.*);

    bind alu_exec_unit alu_exec_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================
    function automatic exp_t ref_exec(alu_op_t op, word_t a, word_t b);
        exp_t   e;
        int     kind;   // 0 logic or move, 1 add, 2 subtract
        longint wide;
        e = '{default: '0};
        e.valid = 1'b1;
        kind = 0;
        if (op.opcode == R_TYPE) begin
            case (op.func)
                ADD:       kind = 1;
                SUB, CMP:  kind = 2;
                AND:       e.value = a & b;
                ORR:       e.value = a | b;
                EOR:       e.value = a ^ b;
                NEG:       e.value = 0 - a;
                LSL, LSLI: e.value = a << b[4:0];
                LSR, LSRI: e.value = a >> b[4:0];
                RET:       e.value = a;
                default:   e.valid = 1'b0;
            endcase
        end else begin
            case (op.opcode)
                ADDI:    kind = 1;
                SUBI:    kind = 2;
                ANDI:    e.value = a & b;
                ORI:     e.value = a | b;
                EORI:    e.value = a ^ b;
                default: e.valid = 1'b0;
            endcase
        end
        if (kind == 1) begin
            e.value   = a + b;
            wide      = longint'($signed(a)) + longint'($signed(b));
            e.flags.c = (e.value < a);  // wrapped past the top
        end else if (kind == 2) begin
            e.value   = a - b;
            wide      = longint'($signed(a)) - longint'($signed(b));
            e.flags.c = (a >= b);
        end
        if (kind != 0)
            e.flags.v = (wide > SMAX) || (wide < SMIN);
        e.flags.n = e.value[`EXEC_XLEN-1];
        e.flags.z = (e.value == 0);
        e.sets    = (kind != 0);
        return e;
    endfunction

    // Ready value, else last result, else CDB
    function automatic void pick_operand(logic ready, preg_tag_t tag, word_t own,
                                         exp_t byp, output word_t val, output logic ok);
        ok  = 1'b1;
        val = own;
        if (!ready) begin
            if (byp.valid && byp.tag == tag)
                val = byp.value;
            else if (cdb_valid && cdb_tag == tag)
                val = cdb_value;
            else
                ok = 1'b0;
        end
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic fail_now(string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp)
            fail_now($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp)
            fail_now($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
    endtask

    task automatic check_tag(string name, preg_tag_t exp, preg_tag_t act);
        if (act !== exp)
            fail_now($sformatf("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act));
    endtask

    task automatic check_rob(string name, rob_tag_t exp, rob_tag_t act);
        if (act !== exp)
            fail_now($sformatf("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act));
    endtask

    task automatic check_flags(string name, nzcv_t exp, nzcv_t act);
        if (act !== exp)
            fail_now($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
    endtask

    // Mid-cycle compare when inputs and outputs have settled
    always @(negedge clk) begin : compare
        exp_t  e;
        exp_t  cur;
        word_t v1;
        word_t v2;
        logic  ok1;
        logic  ok2;
        if (reset) begin
            check_bit("result_valid", 1'b0, result_valid);
            check_bit("bypass_valid", 1'b0, bypass_valid);
            check_flags("flags", 4'b0000, flags);
            sb.delete();
            model_flags = '0;
        end else begin
            check_flags("flags", model_flags, flags);
            e = '{default: '0};
            if (sb.size() > 0)
                e = sb.pop_front();
            check_bit("result_valid", e.valid, result_valid);
            check_bit("bypass_valid", e.valid, bypass_valid);
            if (e.valid) begin
                results_seen++;
                check_word("result_value", e.value, result_value);
                check_tag("result_tag", e.tag, result_tag);
                check_rob("result_rob_tag", e.rob, result_rob_tag);
                // Own result doubles as the bypass
                check_word("bypass_value", e.value, bypass_value);
                check_tag("bypass_tag", e.tag, bypass_tag);
                // NZCV loads on the next edge
                if (e.sets)
                    model_flags = e.flags;
            end
            pick_operand(issue_src1_ready, issue_src1_tag, issue_src1_val, e, v1, ok1);
            pick_operand(issue_src2_ready, issue_src2_tag, issue_src2_val, e, v2, ok2);
            check_bit("issue_accept", issue_valid && ok1 && ok2, issue_accept);
            cur       = ref_exec(issue_op, v1, v2);
            cur.valid = cur.valid && issue_valid && ok1 && ok2;
            cur.tag   = issue_dst_tag;
            cur.rob   = issue_rob_tag;
            sb.push_back(cur);
        end
    end

    // ====================
    // Stimulus
    // ====================
    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    function automatic preg_tag_t small_tag();
        return preg_tag_t'($unsigned($random(seed)) % 8);
    endfunction

    task automatic drive(alu_op_t op, word_t a, word_t b, preg_tag_t dst,
                         logic r1, preg_tag_t t1, logic r2, preg_tag_t t2,
                         logic cv, preg_tag_t ct, word_t cval);
        @(posedge clk);
        issue_valid      <= 1'b1;
        issue_op         <= op;
        issue_dst_tag    <= dst;
        issue_rob_tag    <= rob_tag_t'($random(seed));
        issue_src1_ready <= r1;
        issue_src1_tag   <= t1;
        issue_src1_val   <= a;
        issue_src2_ready <= r2;
        issue_src2_tag   <= t2;
        issue_src2_val   <= b;
        cdb_valid        <= cv;
        cdb_tag          <= ct;
        cdb_value        <= cval;
    endtask

    task automatic send_ready(alu_op_t op, word_t a, word_t b, preg_tag_t dst);
        drive(op, a, b, dst, 1'b1, '0, 1'b1, '0, 1'b0, '0, '0);
    endtask

    task automatic idle();
        @(posedge clk);
        issue_valid <= 1'b0;
        cdb_valid   <= 1'b0;
    endtask

    task automatic apply_reset(int cycles);
        @(posedge clk);
        reset       <= 1'b1;
        issue_valid <= 1'b0;
        cdb_valid   <= 1'b0;
        repeat (cycles) @(posedge clk);
        reset <= 1'b0;
    endtask

    initial begin : stimulus
        alu_op_t op;
        reset            = 1'b1;
        issue_valid      = 1'b0;
        issue_op         = '{R_TYPE, ADD};
        issue_dst_tag    = '0;
        issue_rob_tag    = '0;
        issue_src1_tag   = '0;
        issue_src1_ready = 1'b0;
        issue_src1_val   = '0;
        issue_src2_tag   = '0;
        issue_src2_ready = 1'b0;
        issue_src2_val   = '0;
        cdb_valid        = 1'b0;
        cdb_tag          = '0;
        cdb_value        = '0;
        repeat (RESET_CYC) @(posedge clk);
        reset <= 1'b0;

        // Each recognized op once
        foreach (known_ops[i])
            send_ready(known_ops[i], rand_word(), rand_word(), small_tag());
        // Unknown opcode, then unknown func
        send_ready(alu_op_t'(12'b111111_100000), rand_word(), rand_word(), 6'd1);
        send_ready(alu_op_t'(12'b000000_010101), rand_word(), rand_word(), 6'd2);

        // Dependent chain through the bypass
        send_ready('{R_TYPE, ADD}, 32'd100, 32'd23, 6'd9);
        drive('{R_TYPE, SUB}, 32'hbad0, 32'd5, 6'd10, 1'b0, 6'd9, 1'b1, '0, 1'b0, '0, '0);
        drive('{R_TYPE, ADD}, 32'd7, 32'hbad1, 6'd11, 1'b1, '0, 1'b0, 6'd10, 1'b0, '0, '0);
        idle();
        // CDB hit, then a miss on both paths
        drive('{ANDI, ADD}, 32'hf0f0, 32'h0, 6'd3, 1'b1, '0, 1'b0, 6'd12, 1'b1, 6'd12, 32'hff00);
        drive('{R_TYPE, ORR}, 32'h1, 32'h2, 6'd4, 1'b1, '0, 1'b0, 6'd13, 1'b1, 6'd12, 32'h5);
        // Bypass beats CDB on the same tag
        send_ready('{R_TYPE, EOR}, 32'h55, 32'h0f, 6'd20);
        drive('{R_TYPE, ADD}, 32'h0, 32'h1, 6'd21, 1'b0, 6'd20, 1'b1, '0, 1'b1, 6'd20, 32'hdead);
        idle();

        // Flag edges
        send_ready('{R_TYPE, ADD}, 32'h7fffffff, 32'h1, 6'd5);
        send_ready('{R_TYPE, ADD}, 32'hffffffff, 32'h1, 6'd5);
        send_ready('{R_TYPE, SUB}, 32'h80000000, 32'h1, 6'd5);
        send_ready('{R_TYPE, CMP}, 32'd5, 32'd5, 6'd5);
        send_ready('{SUBI, ADD}, 32'd0, 32'd1, 6'd5);
        send_ready('{ADDI, ADD}, 32'h80000000, 32'h80000000, 6'd5);
        send_ready('{R_TYPE, AND}, 32'h0, 32'h0, 6'd5);
        send_ready('{R_TYPE, NEG}, 32'h1, 32'h0, 6'd5);
        repeat (2) idle();

        // Reset with results in flight
        send_ready('{R_TYPE, ADD}, 32'h7fffffff, 32'h1, 6'd6);
        send_ready('{R_TYPE, SUB}, 32'h1, 32'h2, 6'd7);
        apply_reset(3);
        idle();

        // Random mix with bypass and CDB hits on a small tag range
        repeat (N_RANDOM) begin
            op = known_ops[$unsigned($random(seed)) % 17];
            if (($random(seed) & 15) == 0)
                op = alu_op_t'($random(seed));
            drive(op, rand_word(), rand_word(), small_tag(),
                  ($random(seed) & 3) != 0, small_tag(), ($random(seed) & 3) != 0, small_tag(),
                  $random(seed) & 1, small_tag(), rand_word());
        end
        repeat (3) idle();

        if (DUT.chk.fail_count == 0 && results_seen > 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            fail_now($sformatf("%0d assertion failures, %0d results checked",
                               DUT.chk.fail_count, results_seen));
        end
    end

    // Stimulus length plus margin
    initial begin : watchdog
        #((2 * RESET_CYC + N_DIRECTED + N_RANDOM + 50) * PERIOD);
        fail_now("watchdog timeout, the stimulus did not finish in time");
    end

endmodule

/* alu_exec.f */
+incdir+design
design/isa_pkg.sv
design/core_pkg.sv
design/exec_issue_if.sv
design/operand_bypass.sv
design/alu.sv
design/flag_register.sv
design/alu_exec_unit.sv
sim/alu_exec_checker.sv
sim/alu_exec_tb.sv

/* Bender.yml */
package:
  name: alu_exec

export_include_dirs:
  - design

sources:
  - design/isa_pkg.sv
  - design/core_pkg.sv
  - design/exec_issue_if.sv
  - design/operand_bypass.sv
  - design/alu.sv
  - design/flag_register.sv
  - design/alu_exec_unit.sv
  - target: simulation
    files:
      - sim/alu_exec_checker.sv
      - sim/alu_exec_tb.sv
